/* hw/qdr_config_pkg.sv */
package qdr_config_pkg;

  // opb bus geometry.
  localparam int OPB_DWIDTH  = 32;
  localparam int OPB_BEWIDTH = OPB_DWIDTH / 8;

  // register window in byte addresses.
  localparam logic [31:0] BASE_ADDR = 32'h0001_0000;
  localparam logic [31:0] HIGH_ADDR = 32'h0001_007f;

  // word indices within the window.
  localparam int REG_IDX_W = 5;
  localparam logic [REG_IDX_W-1:0] REG_RESET           = 5'd0;
  localparam logic [REG_IDX_W-1:0] REG_STATUS          = 5'd1;
  localparam logic [REG_IDX_W-1:0] REG_DLY_EN_0        = 5'd4;
  localparam logic [REG_IDX_W-1:0] REG_DLY_EN_1        = 5'd5;
  localparam logic [REG_IDX_W-1:0] REG_DLY_EN_2        = 5'd6;
  localparam logic [REG_IDX_W-1:0] REG_DLY_INC_DEC     = 5'd7;
  localparam logic [REG_IDX_W-1:0] REG_DLY_CNTRS_FIRST = 5'd8;
  localparam logic [REG_IDX_W-1:0] REG_DLY_CNTRS_LAST  = 5'd19;

  // delay element counts.
  localparam int DLY_EN_I_W   = 36;
  localparam int DLY_EN_O_W   = 37;
  localparam int DLY_EN_W     = DLY_EN_I_W + DLY_EN_O_W;
  localparam int DLY_BUNDLE_W = DLY_EN_W + 1;

  // five tap bits per delay element.
  localparam int DLY_CNTRS_W = 5 * DLY_EN_W;

  // counter words rounded up to whole bus words.
  localparam int DLY_CNTRS_PAD_W =
    (REG_DLY_CNTRS_LAST - REG_DLY_CNTRS_FIRST + 1) * OPB_DWIDTH;

  // calibration timing in OPB_Clk cycles.
  localparam int TIMER_W = 16;
  localparam logic [TIMER_W-1:0] RESET_HOLD_CYCLES  = 16'd32;
  localparam logic [TIMER_W-1:0] CAL_TIMEOUT_CYCLES = 16'd2000;

  typedef enum logic [2:0] {
    CAL_IDLE,
    CAL_RESET,
    CAL_WAIT,
    CAL_READY,
    CAL_FAIL
  } cal_state_t;

endpackage

/* hw/qdr_reset_timer.sv */
`timescale 1ns/10ps

module qdr_reset_timer import qdr_config_pkg::*; (
  input  logic               OPB_Clk,
  input  logic               arst_n,
  input  logic               load,
  input  logic [TIMER_W-1:0] value,
  input  logic               run,
  output logic               done
);

  logic [TIMER_W-1:0] count;

  // load wins over the countdown.
  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (load) begin
      count <= value;
    end else if (run && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  // stays high at zero until reloaded.
  assign done = run && (count == '0);

endmodule

/* hw/qdr_cal_fsm.sv */
`timescale 1ns/10ps

module qdr_cal_fsm import qdr_config_pkg::*; (
  input  logic               OPB_Clk,
  input  logic               qdr_clk,
  input  logic               arst_n,
  input  logic               start_cal,
  input  logic               phy_rdy,
  input  logic               cal_fail,
  input  logic               timer_done,
  output logic               timer_load,
  output logic [TIMER_W-1:0] timer_value,
  output logic               timer_run,
  output logic               qdr_reset,
  output logic               phy_rdy_s,
  output logic               cal_fail_s,
  output logic               timeout,
  output cal_state_t         cal_state
);

  cal_state_t state_next;
  logic [1:0] phy_rdy_sync;
  logic [1:0] cal_fail_sync;
  logic       rst_req;
  logic [1:0] qdr_rst_pipe;

  always_comb begin
    state_next = cal_state;
    case (cal_state)
      CAL_IDLE, CAL_READY, CAL_FAIL: begin
        if (start_cal) begin
          state_next = CAL_RESET;
        end
      end
      CAL_RESET: begin
        if (timer_done) begin
          state_next = CAL_WAIT;
        end
      end
      CAL_WAIT: begin
        if (phy_rdy_s) begin
          state_next = CAL_READY;
        end else if (cal_fail_s || timer_done) begin
          state_next = CAL_FAIL;
        end
      end
      default: begin
        state_next = CAL_IDLE;
      end
    endcase
  end

  // timer loads on entry, so a period of n lasts n cycles.
  assign timer_load  = (state_next != cal_state) &&
                       ((state_next == CAL_RESET) || (state_next == CAL_WAIT));
  assign timer_value = (state_next == CAL_RESET) ? RESET_HOLD_CYCLES - 1'b1
                                                 : CAL_TIMEOUT_CYCLES - 1'b1;
  assign timer_run   = (cal_state == CAL_RESET) || (cal_state == CAL_WAIT);

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      cal_state     <= CAL_IDLE;
      phy_rdy_sync  <= '0;
      cal_fail_sync <= '0;
      timeout       <= 1'b0;
      rst_req       <= 1'b0;
    end else begin
      cal_state     <= state_next;
      phy_rdy_sync  <= {phy_rdy_sync[0], phy_rdy};
      cal_fail_sync <= {cal_fail_sync[0], cal_fail};
      rst_req       <= (state_next == CAL_RESET);
      if (state_next == CAL_RESET) begin
        timeout <= 1'b0;
      end else if (cal_state == CAL_WAIT && !phy_rdy_s && !cal_fail_s && timer_done) begin
        timeout <= 1'b1;
      end
    end
  end

  assign phy_rdy_s  = phy_rdy_sync[1];
  assign cal_fail_s = cal_fail_sync[1];

  // reset request into the qdr clock domain.
  always_ff @(posedge qdr_clk or negedge arst_n) begin
    if (!arst_n) begin
      qdr_rst_pipe <= '0;
    end else begin
      qdr_rst_pipe <= {qdr_rst_pipe[0], rst_req};
    end
  end

  assign qdr_reset = qdr_rst_pipe[1];

endmodule

/* hw/qdr_opb_regs.sv */
`timescale 1ns/10ps

module qdr_opb_regs import qdr_config_pkg::*; (
  input  logic                   OPB_Clk,
  input  logic                   arst_n,
  input  logic [0:OPB_DWIDTH-1]  OPB_ABus,
  input  logic [0:OPB_BEWIDTH-1] OPB_BE,
  input  logic [0:OPB_DWIDTH-1]  OPB_DBus,
  input  logic                   OPB_RNW,
  input  logic                   OPB_select,
  input  logic [DLY_CNTRS_W-1:0] dly_cntrs,
  input  logic                   phy_rdy_s,
  input  logic                   cal_fail_s,
  input  logic                   timeout,
  input  cal_state_t             cal_state,
  output logic [0:OPB_DWIDTH-1]  Sl_DBus,
  output logic                   Sl_xferAck,
  output logic                   start_cal,
  output logic [DLY_EN_I_W-1:0]  dly_en_i_reg,
  output logic [DLY_EN_O_W-1:0]  dly_en_o_reg,
  output logic                   dly_inc_dec_reg
);

  logic [OPB_DWIDTH-1:0]      addr;
  logic [OPB_DWIDTH-1:0]      addr_off;
  logic [OPB_DWIDTH-1:0]      wdata;
  logic [OPB_BEWIDTH-1:0]     be;
  logic [REG_IDX_W-1:0]       word_idx;
  logic                       in_window;
  logic                       accept;
  logic                       xfer_ack;
  logic [REG_IDX_W-1:0]       word_sel;
  logic [OPB_DWIDTH-1:0]      en1_word;
  logic [OPB_DWIDTH-1:0]      en1_merged;
  logic [DLY_CNTRS_PAD_W-1:0] cntrs_pad;
  logic [REG_IDX_W-1:0]       cntr_word;
  logic [OPB_DWIDTH-1:0]      rd_word;

  // replace the enabled byte lanes of cur with wr.
  function automatic logic [OPB_DWIDTH-1:0] be_merge(
    input logic [OPB_DWIDTH-1:0]  cur,
    input logic [OPB_DWIDTH-1:0]  wr,
    input logic [OPB_BEWIDTH-1:0] lanes
  );
    logic [OPB_DWIDTH-1:0] res;
    res = cur;
    for (int k = 0; k < OPB_BEWIDTH; k++) begin
      if (lanes[k]) begin
        res[8*k +: 8] = wr[8*k +: 8];
      end
    end
    return res;
  endfunction

  // renumber bus words so bit 0 is the lsb (bus bit 31).
  assign addr  = OPB_ABus;
  assign wdata = OPB_DBus;
  assign be    = OPB_BE;

  assign addr_off  = addr - BASE_ADDR;
  assign word_idx  = addr_off[REG_IDX_W+1:2];
  assign in_window = (addr >= BASE_ADDR) && (addr <= HIGH_ADDR);

  // no accept in the cycle right after an ack.
  assign accept = OPB_select && in_window && !xfer_ack;

  // upper enable bits share one word.
  assign en1_word   = {23'b0, dly_en_o_reg[36:32], dly_en_i_reg[35:32]};
  assign en1_merged = be_merge(en1_word, wdata, be);

  always_ff @(posedge OPB_Clk or negedge arst_n) begin
    if (!arst_n) begin
      xfer_ack        <= 1'b0;
      word_sel        <= '0;
      start_cal       <= 1'b0;
      dly_en_i_reg    <= '0;
      dly_en_o_reg    <= '0;
      dly_inc_dec_reg <= 1'b0;
    end else begin
      xfer_ack  <= accept;
      start_cal <= 1'b0;
      if (accept) begin
        word_sel <= word_idx;
      end
      if (accept && !OPB_RNW) begin
        case (word_idx)
          REG_RESET: begin
            start_cal <= be[0] & wdata[0];
          end
          REG_DLY_EN_0: begin
            dly_en_i_reg[31:0] <= be_merge(dly_en_i_reg[31:0], wdata, be);
          end
          REG_DLY_EN_1: begin
            dly_en_i_reg[35:32] <= en1_merged[3:0];
            dly_en_o_reg[36:32] <= en1_merged[8:4];
          end
          REG_DLY_EN_2: begin
            dly_en_o_reg[31:0] <= be_merge(dly_en_o_reg[31:0], wdata, be);
          end
          REG_DLY_INC_DEC: begin
            if (be[0]) begin
              dly_inc_dec_reg <= wdata[0];
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // tap counters padded with zeros above bit 364.
  assign cntrs_pad = {{(DLY_CNTRS_PAD_W-DLY_CNTRS_W){1'b0}}, dly_cntrs};
  assign cntr_word = word_sel - REG_DLY_CNTRS_FIRST;

  always_comb begin
    rd_word = '0;
    case (word_sel)
      REG_STATUS: begin
        rd_word = {13'b0, cal_state, 6'b0, timeout, cal_fail_s, 7'b0, phy_rdy_s};
      end
      REG_DLY_EN_0: begin
        rd_word = dly_en_i_reg[31:0];
      end
      REG_DLY_EN_1: begin
        rd_word = en1_word;
      end
      REG_DLY_EN_2: begin
        rd_word = dly_en_o_reg[31:0];
      end
      REG_DLY_INC_DEC: begin
        rd_word = {31'b0, dly_inc_dec_reg};
      end
      default: begin
        if (word_sel >= REG_DLY_CNTRS_FIRST && word_sel <= REG_DLY_CNTRS_LAST) begin
          rd_word = cntrs_pad[cntr_word*OPB_DWIDTH +: OPB_DWIDTH];
        end
      end
    endcase
  end

  // read data only during the ack cycle.
  assign Sl_DBus    = xfer_ack ? rd_word : '0;
  assign Sl_xferAck = xfer_ack;

endmodule

/* hw/clk_domain_crosser.sv */
`timescale 1ns/10ps

module clk_domain_crosser #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  in_clk,
  input  logic                  out_clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0] data_out
);

  logic [DATA_WIDTH-1:0] hold;
  logic                  req_tgl;
  logic [1:0]            ack_sync;
  logic [2:0]            req_sync;
  logic                  ack_tgl;
  logic                  idle;

  // previous round has been acknowledged.
  assign idle = (req_tgl == ack_sync[1]);

  // hold stays stable while a round is in flight.
  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      hold     <= '0;
      req_tgl  <= 1'b0;
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[0], ack_tgl};
      if (idle && (data_in != hold)) begin
        hold    <= data_in;
        req_tgl <= ~req_tgl;
      end
    end
  end

  always_ff @(posedge out_clk or negedge arst_n) begin
    if (!arst_n) begin
      req_sync <= '0;
      data_out <= '0;
    end else begin
      req_sync <= {req_sync[1:0], req_tgl};
      if (req_sync[2] != req_sync[1]) begin
        data_out <= hold;
      end
    end
  end

  // ack flips together with the data latch.
  assign ack_tgl = req_sync[2];

endmodule

/* hw/edge_detect.sv */
`timescale 1ns/10ps

module edge_detect #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] in,
  output logic [DATA_WIDTH-1:0] pulse_out
);

  logic [DATA_WIDTH-1:0] in_q;

  // one pulse per rising bit.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_q      <= '0;
      pulse_out <= '0;
    end else begin
      in_q      <= in;
      pulse_out <= in & ~in_q;
    end
  end

endmodule

/* hw/qdr_config.sv */
`timescale 1ns/10ps

module qdr_config import qdr_config_pkg::*; (
  input  logic                   OPB_Clk,
  input  logic                   arst_n,
  input  logic [0:OPB_DWIDTH-1]  OPB_ABus,
  input  logic [0:OPB_BEWIDTH-1] OPB_BE,
  input  logic [0:OPB_DWIDTH-1]  OPB_DBus,
  input  logic                   OPB_RNW,
  input  logic                   OPB_select,
  output logic [0:OPB_DWIDTH-1]  Sl_DBus,
  output logic                   Sl_xferAck,
  output logic                   Sl_errAck,
  output logic                   Sl_retry,
  output logic                   Sl_toutSup,
  input  logic                   dly_clk,
  output logic [DLY_EN_I_W-1:0]  dly_en_i,
  output logic [DLY_EN_O_W-1:0]  dly_en_o,
  output logic                   dly_inc_dec,
  input  logic [DLY_CNTRS_W-1:0] dly_cntrs,
  input  logic                   qdr_clk,
  output logic                   qdr_reset,
  input  logic                   phy_rdy,
  input  logic                   cal_fail
);

  logic                    start_cal;
  logic [DLY_EN_I_W-1:0]   dly_en_i_reg;
  logic [DLY_EN_O_W-1:0]   dly_en_o_reg;
  logic                    dly_inc_dec_reg;
  logic                    phy_rdy_s;
  logic                    cal_fail_s;
  logic                    timeout;
  cal_state_t              cal_state;
  logic                    timer_load;
  logic [TIMER_W-1:0]      timer_value;
  logic                    timer_run;
  logic                    timer_done;
  logic [DLY_BUNDLE_W-1:0] dly_crossed;

  // no error, retry or timeout suppress.
  assign Sl_errAck  = 1'b0;
  assign Sl_retry   = 1'b0;
  assign Sl_toutSup = 1'b0;

  qdr_opb_regs regs0 (
    .OPB_Clk         (OPB_Clk),
    .arst_n          (arst_n),
    .OPB_ABus        (OPB_ABus),
    .OPB_BE          (OPB_BE),
    .OPB_DBus        (OPB_DBus),
    .OPB_RNW         (OPB_RNW),
    .OPB_select      (OPB_select),
    .dly_cntrs       (dly_cntrs),
    .phy_rdy_s       (phy_rdy_s),
    .cal_fail_s      (cal_fail_s),
    .timeout         (timeout),
    .cal_state       (cal_state),
    .Sl_DBus         (Sl_DBus),
    .Sl_xferAck      (Sl_xferAck),
    .start_cal       (start_cal),
    .dly_en_i_reg    (dly_en_i_reg),
    .dly_en_o_reg    (dly_en_o_reg),
    .dly_inc_dec_reg (dly_inc_dec_reg)
  );

  qdr_cal_fsm cal0 (
    .OPB_Clk     (OPB_Clk),
    .qdr_clk     (qdr_clk),
    .arst_n      (arst_n),
    .start_cal   (start_cal),
    .phy_rdy     (phy_rdy),
    .cal_fail    (cal_fail),
    .timer_done  (timer_done),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .timer_run   (timer_run),
    .qdr_reset   (qdr_reset),
    .phy_rdy_s   (phy_rdy_s),
    .cal_fail_s  (cal_fail_s),
    .timeout     (timeout),
    .cal_state   (cal_state)
  );

  qdr_reset_timer timer0 (
    .OPB_Clk (OPB_Clk),
    .arst_n  (arst_n),
    .load    (timer_load),
    .value   (timer_value),
    .run     (timer_run),
    .done    (timer_done)
  );

  // enables and direction cross into dly_clk together.
  clk_domain_crosser #(
    .DATA_WIDTH (DLY_BUNDLE_W)
  ) xing0 (
    .in_clk   (OPB_Clk),
    .out_clk  (dly_clk),
    .arst_n   (arst_n),
    .data_in  ({dly_en_i_reg, dly_en_o_reg, dly_inc_dec_reg}),
    .data_out (dly_crossed)
  );

  assign dly_inc_dec = dly_crossed[0];

  edge_detect #(
    .DATA_WIDTH (DLY_EN_W)
  ) edge0 (
    .clk       (dly_clk),
    .arst_n    (arst_n),
    .in        (dly_crossed[DLY_BUNDLE_W-1:1]),
    .pulse_out ({dly_en_i, dly_en_o})
  );

endmodule

/* tests/qdr_config_tb.sv */
`timescale 1ns/10ps

module qdr_config_tb import qdr_config_pkg::*; ();

  localparam int OPB_PERIOD        = 8;
  localparam int ACK_LIMIT         = 16;
  localparam int SETTLE_DLY_CYCLES = 48;
  localparam int PHY_NONE          = 0;
  localparam int PHY_RDY           = 1;
  localparam int PHY_FAIL          = 2;
  localparam int CAL_POLL_LIMIT    =
    int'(RESET_HOLD_CYCLES) + int'(CAL_TIMEOUT_CYCLES) + 100;
  // reset, registers, delays, counters, three calibrations, margin.
  localparam int WATCHDOG_CYCLES   = 10 + 200 + 300 + 100 + 3 * (CAL_POLL_LIMIT + 50) + 500;

  logic                   OPB_Clk = 1'b0;
  logic                   dly_clk = 1'b0;
  logic                   qdr_clk = 1'b0;
  logic                   arst_n;
  logic [0:OPB_DWIDTH-1]  OPB_ABus;
  logic [0:OPB_BEWIDTH-1] OPB_BE;
  logic [0:OPB_DWIDTH-1]  OPB_DBus;
  logic                   OPB_RNW;
  logic                   OPB_select;
  logic [0:OPB_DWIDTH-1]  Sl_DBus;
  logic                   Sl_xferAck;
  logic                   Sl_errAck;
  logic                   Sl_retry;
  logic                   Sl_toutSup;
  logic [DLY_EN_I_W-1:0]  dly_en_i;
  logic [DLY_EN_O_W-1:0]  dly_en_o;
  logic                   dly_inc_dec;
  logic [DLY_CNTRS_W-1:0] dly_cntrs;
  logic                   qdr_reset;
  logic                   phy_rdy   = 1'b0;
  logic                   cal_fail  = 1'b0;
  logic                   phy_armed = 1'b0;
  int                     phy_cnt   = 0;
  int                     phy_mode  = PHY_NONE;
  int                     phy_delay = 20;
  int unsigned            opb_cyc   = 0;
  int                     pulse_cnt [DLY_EN_W];
  int                     base_cnt  [DLY_EN_W];
  logic [DLY_EN_W-1:0]    pulse_vec;
  int                     err_cnt   = 0;
  int                     tests_run = 0;
  int                     tests_bad = 0;
  int                     ack_lat;
  logic                   ack_seen;

  always #(OPB_PERIOD / 2) OPB_Clk = ~OPB_Clk;
  always #5 dly_clk = ~dly_clk;
  always #3 qdr_clk = ~qdr_clk;

  always @(posedge OPB_Clk) begin
    opb_cyc <= opb_cyc + 1;
  end

  qdr_config dut0 (
    .OPB_Clk     (OPB_Clk),
    .arst_n      (arst_n),
    .OPB_ABus    (OPB_ABus),
    .OPB_BE      (OPB_BE),
    .OPB_DBus    (OPB_DBus),
    .OPB_RNW     (OPB_RNW),
    .OPB_select  (OPB_select),
    .Sl_DBus     (Sl_DBus),
    .Sl_xferAck  (Sl_xferAck),
    .Sl_errAck   (Sl_errAck),
    .Sl_retry    (Sl_retry),
    .Sl_toutSup  (Sl_toutSup),
    .dly_clk     (dly_clk),
    .dly_en_i    (dly_en_i),
    .dly_en_o    (dly_en_o),
    .dly_inc_dec (dly_inc_dec),
    .dly_cntrs   (dly_cntrs),
    .qdr_clk     (qdr_clk),
    .qdr_reset   (qdr_reset),
    .phy_rdy     (phy_rdy),
    .cal_fail    (cal_fail)
  );

  // phy model answering a set delay after qdr_reset falls.
  always @(posedge qdr_clk) begin
    if (qdr_reset) begin
      phy_rdy   <= 1'b0;
      cal_fail  <= 1'b0;
      phy_cnt   <= 0;
      phy_armed <= 1'b1;
    end else if (phy_armed) begin
      if (phy_cnt == phy_delay) begin
        phy_rdy   <= (phy_mode == PHY_RDY);
        cal_fail  <= (phy_mode == PHY_FAIL);
        phy_armed <= 1'b0;
      end else begin
        phy_cnt <= phy_cnt + 1;
      end
    end
  end

  // pulse monitor with the i enables above the o enables.
  assign pulse_vec = {dly_en_i, dly_en_o};

  always @(negedge dly_clk) begin
    for (int j = 0; j < DLY_EN_W; j++) begin
      if (pulse_vec[j]) begin
        pulse_cnt[j] = pulse_cnt[j] + 1;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * OPB_PERIOD);
    $display("watchdog: run did not finish within %0d OPB_Clk cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_state(input string name, input cal_state_t got, input cal_state_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h (%s), expected 0x%h (%s)",
               name, got, got.name(), exp, exp.name());
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  // error, retry and timeout suppress stay low.
  task automatic check_tied_low();
    check_bit("Sl_errAck", Sl_errAck, 1'b0);
    check_bit("Sl_retry", Sl_retry, 1'b0);
    check_bit("Sl_toutSup", Sl_toutSup, 1'b0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  function automatic logic [31:0] reg_addr(input logic [REG_IDX_W-1:0] idx);
    return BASE_ADDR + {25'b0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // one opb transfer whose outcome lands in ack_seen and ack_lat.
  task automatic bus_cycle(input logic rnw, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited   = 0;
    ack_seen = 1'b0;
    rdata    = '0;
    @(posedge OPB_Clk);
    OPB_ABus   <= addr;
    OPB_BE     <= be;
    OPB_DBus   <= wdata;
    OPB_RNW    <= rnw;
    OPB_select <= 1'b1;
    while (!ack_seen && waited < ACK_LIMIT) begin
      @(negedge OPB_Clk);
      check_tied_low();
      if (Sl_xferAck) begin
        ack_seen = 1'b1;
        rdata    = Sl_DBus;
      end else begin
        check_word("Sl_DBus without ack", Sl_DBus, 32'h0);
        waited++;
      end
    end
    ack_lat = waited;
    @(posedge OPB_Clk);
    OPB_select <= 1'b0;
    OPB_RNW    <= 1'b0;
    OPB_ABus   <= '0;
    OPB_BE     <= '0;
    OPB_DBus   <= '0;
    @(negedge OPB_Clk);
    check_bit("Sl_xferAck after ack cycle", Sl_xferAck, 1'b0);
    check_word("Sl_DBus after ack cycle", Sl_DBus, 32'h0);
  endtask

  task automatic opb_write(input logic [31:0] addr, input logic [3:0] be, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b0, addr, be, data, unused);
    if (!ack_seen) begin
      $display("no acknowledge for write to 0x%h within %0d cycles", addr, ACK_LIMIT);
      err_cnt++;
    end
  endtask

  task automatic opb_read(input logic [31:0] addr, output logic [31:0] data);
    bus_cycle(1'b1, addr, 4'hf, 32'h0, data);
    if (!ack_seen) begin
      $display("no acknowledge for read of 0x%h within %0d cycles", addr, ACK_LIMIT);
      err_cnt++;
    end
  endtask

  task automatic read_status(output cal_state_t st, output logic rdy, output logic fail,
                             output logic tout);
    logic [31:0] w;
    opb_read(reg_addr(REG_STATUS), w);
    st   = cal_state_t'(w[18:16]);
    rdy  = w[0];
    fail = w[8];
    tout = w[9];
  endtask

  // delay crossings finish well inside this many dly_clk cycles.
  task automatic settle_delays();
    repeat (SETTLE_DLY_CYCLES) @(negedge dly_clk);
  endtask

  task automatic compare_pulses(input logic [35:0] exp_i, input logic [36:0] exp_o);
    logic [DLY_EN_W-1:0] once;
    logic [DLY_EN_W-1:0] extra;
    int d;
    for (int j = 0; j < DLY_EN_W; j++) begin
      d        = pulse_cnt[j] - base_cnt[j];
      once[j]  = (d == 1);
      extra[j] = (d > 1);
    end
    check_word("dly_en_i[31:0] pulses", once[68:37], exp_i[31:0]);
    check_word("dly_en_o[31:0] pulses", once[31:0], exp_o[31:0]);
    check_word("dly_en upper pulses", {23'b0, once[36:32], once[72:69]},
               {23'b0, exp_o[36:32], exp_i[35:32]});
    check_bit("repeated dly_en pulse", |extra, 1'b0);
  endtask

  task automatic register_access();
    int errs;
    logic [31:0] v [4];
    logic [31:0] rd;
    logic [31:0] nv;
    logic [31:0] m;
    cal_state_t  st;
    logic        rdy;
    logic        fail;
    logic        tout;
    errs = err_cnt;
    check_bit("Sl_xferAck after reset", Sl_xferAck, 1'b0);
    check_bit("qdr_reset after reset", qdr_reset, 1'b0);
    check_bit("dly_en after reset", |pulse_vec, 1'b0);
    check_tied_low();
    read_status(st, rdy, fail, tout);
    check_state("state after reset", st, CAL_IDLE);
    opb_read(reg_addr(REG_DLY_EN_0), rd);
    check_word("DLY_EN_0 after reset", rd, 32'h0);
    check_word("read ack latency", 32'(ack_lat), 32'd1);
    for (int k = 0; k < 4; k++) begin
      v[k] = $urandom;
      opb_write(reg_addr(REG_DLY_EN_0 + 5'(k)), 4'hf, v[k]);
      check_word("write ack latency", 32'(ack_lat), 32'd1);
    end
    opb_read(reg_addr(REG_DLY_EN_0), rd);
    check_word("DLY_EN_0", rd, v[0]);
    opb_read(reg_addr(REG_DLY_EN_1), rd);
    check_word("DLY_EN_1", rd, v[1] & 32'h0000_01ff);
    opb_read(reg_addr(REG_DLY_EN_2), rd);
    check_word("DLY_EN_2", rd, v[2]);
    opb_read(reg_addr(REG_DLY_INC_DEC), rd);
    check_word("DLY_INC_DEC", rd, v[3] & 32'h1);
    // partial lane writes.
    nv = $urandom;
    m  = lane_mask(4'b0101);
    opb_write(reg_addr(REG_DLY_EN_0), 4'b0101, nv);
    opb_read(reg_addr(REG_DLY_EN_0), rd);
    check_word("DLY_EN_0 lanes 0 and 2", rd, (v[0] & ~m) | (nv & m));
    nv = $urandom;
    m  = lane_mask(4'b0010);
    opb_write(reg_addr(REG_DLY_EN_1), 4'b0010, nv);
    opb_read(reg_addr(REG_DLY_EN_1), rd);
    check_word("DLY_EN_1 lane 1", rd, ((v[1] & ~m) | (nv & m)) & 32'h0000_01ff);
    for (int w = 0; w < 32; w++) begin
      if (w == 0 || w == 2 || w == 3 || w >= 20) begin
        opb_read(reg_addr(5'(w)), rd);
        check_word($sformatf("unmapped word %0d", w), rd, 32'h0);
      end
    end
    bus_cycle(1'b1, HIGH_ADDR + 32'd1, 4'hf, 32'h0, rd);
    check_bit("Sl_xferAck above window", ack_seen, 1'b0);
    bus_cycle(1'b0, BASE_ADDR - 32'd4, 4'hf, 32'hffff_ffff, rd);
    check_bit("Sl_xferAck below window", ack_seen, 1'b0);
    report_test("register access", errs);
  endtask

  task automatic delay_pulses();
    int errs;
    logic [63:0] rnd;
    logic [35:0] pat_i;
    logic [36:0] pat_o;
    logic        inc;
    errs  = err_cnt;
    rnd   = {$urandom, $urandom};
    pat_i = rnd[35:0];
    rnd   = {$urandom, $urandom};
    pat_o = rnd[36:0];
    inc   = rnd[40];
    for (int k = 0; k < 3; k++) begin
      opb_write(reg_addr(REG_DLY_EN_0 + 5'(k)), 4'hf, 32'h0);
    end
    // direction starts opposite to the one under test.
    opb_write(reg_addr(REG_DLY_INC_DEC), 4'hf, {31'b0, ~inc});
    settle_delays();
    for (int pass = 0; pass < 2; pass++) begin
      base_cnt = pulse_cnt;
      opb_write(reg_addr(REG_DLY_EN_0), 4'hf, pat_i[31:0]);
      opb_write(reg_addr(REG_DLY_EN_1), 4'hf, {23'b0, pat_o[36:32], pat_i[35:32]});
      opb_write(reg_addr(REG_DLY_EN_2), 4'hf, pat_o[31:0]);
      opb_write(reg_addr(REG_DLY_INC_DEC), 4'hf, {31'b0, inc});
      settle_delays();
      // the second pass rewrites the same pattern.
      if (pass == 0) begin
        compare_pulses(pat_i, pat_o);
      end else begin
        compare_pulses('0, '0);
      end
      check_bit("dly_inc_dec", dly_inc_dec, inc);
    end
    report_test("delay pulses", errs);
  endtask

  task automatic counter_readback();
    int errs;
    logic [383:0] cpad;
    logic [31:0]  rd;
    errs = err_cnt;
    for (int k = 0; k < 12; k++) begin
      cpad[32*k +: 32] = $urandom;
    end
    cpad[383:DLY_CNTRS_W] = '0;
    @(posedge OPB_Clk);
    dly_cntrs <= cpad[DLY_CNTRS_W-1:0];
    for (int k = 0; k < 12; k++) begin
      opb_read(reg_addr(REG_DLY_CNTRS_FIRST + 5'(k)), rd);
      check_word($sformatf("counter word %0d", k), rd, cpad[32*k +: 32]);
    end
    report_test("counter readback", errs);
  endtask

  task automatic start_calibration();
    cal_state_t st;
    logic rdy;
    logic fail;
    logic tout;
    int waited;
    opb_write(reg_addr(REG_RESET), 4'hf, 32'h1);
    waited = 0;
    while (!qdr_reset && waited < ACK_LIMIT) begin
      @(negedge OPB_Clk);
      waited++;
    end
    if (!qdr_reset) begin
      $display("qdr_reset did not rise within %0d cycles of the start", ACK_LIMIT);
      err_cnt++;
    end
    read_status(st, rdy, fail, tout);
    check_state("state after start", st, CAL_RESET);
  endtask

  task automatic wait_cal_result(output cal_state_t st, output logic rdy, output logic fail,
                                 output logic tout);
    int unsigned start;
    start = opb_cyc;
    read_status(st, rdy, fail, tout);
    while (st != CAL_READY && st != CAL_FAIL && int'(opb_cyc - start) < CAL_POLL_LIMIT) begin
      read_status(st, rdy, fail, tout);
    end
    if (st != CAL_READY && st != CAL_FAIL) begin
      $display("calibration did not finish within %0d cycles", CAL_POLL_LIMIT);
      err_cnt++;
    end
  endtask

  task automatic run_calibration(input string name, input int mode, input cal_state_t exp_st,
                                 input logic exp_rdy, input logic exp_fail, input logic exp_tout);
    int errs;
    cal_state_t st;
    logic rdy;
    logic fail;
    logic tout;
    errs     = err_cnt;
    phy_mode = mode;
    start_calibration();
    wait_cal_result(st, rdy, fail, tout);
    check_state("cal_state", st, exp_st);
    check_bit("phy_rdy_s", rdy, exp_rdy);
    check_bit("cal_fail_s", fail, exp_fail);
    check_bit("timeout", tout, exp_tout);
    check_bit("qdr_reset", qdr_reset, 1'b0);
    report_test(name, errs);
  endtask

  initial begin
    void'($urandom(31));
    arst_n     = 1'b0;
    OPB_ABus   = '0;
    OPB_BE     = '0;
    OPB_DBus   = '0;
    OPB_RNW    = 1'b0;
    OPB_select = 1'b0;
    dly_cntrs  = '0;
    repeat (10) @(posedge OPB_Clk);
    arst_n <= 1'b1;
    @(posedge OPB_Clk);
    register_access();
    delay_pulses();
    counter_readback();
    run_calibration("calibration ready", PHY_RDY, CAL_READY, 1'b1, 1'b0, 1'b0);
    run_calibration("calibration fail", PHY_FAIL, CAL_FAIL, 1'b0, 1'b1, 1'b0);
    run_calibration("calibration timeout", PHY_NONE, CAL_FAIL, 1'b0, 1'b0, 1'b1);
    $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
hw/qdr_config_pkg.sv
hw/qdr_reset_timer.sv
hw/qdr_cal_fsm.sv
hw/qdr_opb_regs.sv
hw/clk_domain_crosser.sv
hw/edge_detect.sv
hw/qdr_config.sv
tests/qdr_config_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the qdr_config testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/qdr_config_sim

verilator --binary --timing -Mdir obj_dir --top-module qdr_config_tb \
  -f compile.f -o qdr_config_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi

exit 0
